//--- verilog/rv_isa_pkg.sv
// RV32 ISA encodings
// Major opcodes, funct fields and the raw instruction layout

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_EXT1   = 7'b0001011,  // custom-0, warp control
        OP_FENCE  = 7'b0001111,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // funct3 of OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'h0;
    localparam logic [2:0] F3_SLL     = 3'h1;
    localparam logic [2:0] F3_SLT     = 3'h2;
    localparam logic [2:0] F3_SLTU    = 3'h3;
    localparam logic [2:0] F3_XOR     = 3'h4;
    localparam logic [2:0] F3_SR      = 3'h5;  // SRL or SRA by funct7[5]
    localparam logic [2:0] F3_OR      = 3'h6;
    localparam logic [2:0] F3_AND     = 3'h7;

    // funct3 of branches
    localparam logic [2:0] F3_BEQ  = 3'h0;
    localparam logic [2:0] F3_BNE  = 3'h1;
    localparam logic [2:0] F3_BLT  = 3'h4;
    localparam logic [2:0] F3_BGE  = 3'h5;
    localparam logic [2:0] F3_BLTU = 3'h6;
    localparam logic [2:0] F3_BGEU = 3'h7;

    // Warp control, funct7 = 0
    localparam logic [6:0] F7_WCTL   = 7'h00;
    localparam logic [2:0] F3_TMC    = 3'h0;
    localparam logic [2:0] F3_WSPAWN = 3'h1;
    localparam logic [2:0] F3_SPLIT  = 3'h2;
    localparam logic [2:0] F3_JOIN   = 3'h3;
    localparam logic [2:0] F3_BAR    = 3'h4;
    localparam logic [2:0] F3_PRED   = 3'h5;

    // funct12 of the trap and return group
    localparam logic [11:0] F12_ECALL  = 12'h000;
    localparam logic [11:0] F12_EBREAK = 12'h001;
    localparam logic [11:0] F12_URET   = 12'h002;
    localparam logic [11:0] F12_SRET   = 12'h102;
    localparam logic [11:0] F12_MRET   = 12'h302;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } rv_instr_t;

endpackage

//--- verilog/gpu_decode_pkg.sv
// GPU decode stage types
// Core widths, execution-unit and operation codes, pipeline records

package gpu_decode_pkg;

    localparam int NUM_THREADS = 4;
    localparam int NUM_WARPS   = 4;
    localparam int UUID_W      = 8;
    localparam int XLEN        = 32;
    localparam int WID_W       = $clog2(NUM_WARPS);
    localparam int NREG_W      = 5;
    localparam int OP_W        = 4;
    localparam int MOD_W       = 3;

    // op_mod bit positions
    localparam int MOD_BRANCH = 0;
    localparam int MOD_MULDIV = 1;

    typedef enum logic [1:0] {
        EX_ALU = 2'd0,
        EX_LSU = 2'd1,
        EX_SFU = 2'd2
    } ex_type_e;

    typedef enum logic [OP_W-1:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI, ALU_AUIPC
    } alu_op_e;

    typedef enum logic [OP_W-1:0] {
        BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_JAL, BR_JALR,
        BR_ECALL, BR_EBREAK, BR_URET, BR_SRET, BR_MRET
    } br_op_e;

    // Same order as funct3
    typedef enum logic [OP_W-1:0] {
        MUL_MUL, MUL_MULH, MUL_MULHSU, MUL_MULHU,
        MUL_DIV, MUL_DIVU, MUL_REM, MUL_REMU
    } mul_op_e;

    typedef enum logic [OP_W-1:0] {
        SFU_TMC, SFU_WSPAWN, SFU_SPLIT, SFU_JOIN, SFU_BAR, SFU_PRED,
        SFU_CSRRW, SFU_CSRRS, SFU_CSRRC
    } sfu_op_e;

    // Loads and stores use {store, funct3}
    localparam logic [OP_W-1:0] LSU_FENCE = 4'd15;

    typedef struct packed {
        logic [UUID_W-1:0]      uuid;
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        rv_isa_pkg::rv_instr_t  instr;
    } fetch_t;

    typedef struct packed {
        logic [UUID_W-1:0]      uuid;
        logic [WID_W-1:0]       wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [XLEN-1:0]        pc;
        ex_type_e               ex_type;
        logic [OP_W-1:0]        op_type;
        logic [MOD_W-1:0]       op_mod;
        logic                   use_pc;
        logic [XLEN-1:0]        imm;
        logic                   use_imm;
        logic                   wb;
        logic [NREG_W-1:0]      rd;
        logic [NREG_W-1:0]      rs1;
        logic [NREG_W-1:0]      rs2;
    } decode_t;

    typedef struct packed {
        logic             valid;
        logic [WID_W-1:0] wid;
        logic             wstall;
    } sched_t;

endpackage

//--- verilog/imm_gen.sv
// Immediate generator
// Reassembles and sign-extends the I, S, B, U and J immediates,
// plus the CSR address / zimm word

`timescale 1ns/10ps

module imm_gen (
    input  rv_isa_pkg::rv_instr_t instr,
    output logic [31:0]           imm_i,
    output logic [31:0]           imm_s,
    output logic [31:0]           imm_b,
    output logic [31:0]           imm_u,
    output logic [31:0]           imm_j,
    output logic [31:0]           imm_csr
);
    import rv_isa_pkg::*;

    logic [31:0] ir;
    logic [11:0] i_raw;
    logic        shift_form;

    assign ir    = instr;
    assign i_raw = ir[31:20];

    // SLLI/SRLI/SRAI carry a shamt, not a signed immediate
    assign shift_form = (instr.opcode == OP_IMM) &&
                        ((instr.funct3 == F3_SLL) || (instr.funct3 == F3_SR));

    assign imm_i = shift_form ? {27'b0, instr.rs2} : {{20{i_raw[11]}}, i_raw};
    assign imm_s = {{20{ir[31]}}, instr.funct7, instr.rd};
    assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
    assign imm_u = {ir[31:12], 12'b0};
    assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

    // Address in [11:0], zimm in [16:12] for the immediate forms
    assign imm_csr = {15'b0, (instr.funct3[2] ? instr.rs1 : 5'b0), i_raw};

endmodule

//--- verilog/op_func_map.sv
// Operation tables
// funct3/funct7 to ALU, branch, multiply and SFU codes, funct12 to trap/return

`timescale 1ns/10ps

module op_func_map (
    input  rv_isa_pkg::rv_instr_t    instr,
    output gpu_decode_pkg::alu_op_e  alu_op,
    output gpu_decode_pkg::br_op_e   br_op,
    output gpu_decode_pkg::br_op_e   sys_op,
    output gpu_decode_pkg::mul_op_e  mul_op,
    output gpu_decode_pkg::sfu_op_e  sfu_op
);
    import rv_isa_pkg::*;
    import gpu_decode_pkg::*;

    logic [11:0] funct12;

    assign funct12 = {instr.funct7, instr.rs2};
    assign mul_op  = mul_op_e'(instr.funct3);

    always_comb begin
        alu_op = ALU_ADD;
        case (instr.funct3)
            F3_ADD_SUB: alu_op = (instr.opcode == OP_REG && instr.funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SR:      alu_op = instr.funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (instr.funct3)
            F3_BNE:  br_op = BR_NE;
            F3_BLT:  br_op = BR_LT;
            F3_BGE:  br_op = BR_GE;
            F3_BLTU: br_op = BR_LTU;
            F3_BGEU: br_op = BR_GEU;
            F3_BEQ:  br_op = BR_EQ;
            default: br_op = BR_EQ;  // Reserved encodings
        endcase
    end

    always_comb begin
        case (funct12)
            F12_EBREAK: sys_op = BR_EBREAK;
            F12_URET:   sys_op = BR_URET;
            F12_SRET:   sys_op = BR_SRET;
            F12_MRET:   sys_op = BR_MRET;
            F12_ECALL:  sys_op = BR_ECALL;
            default:    sys_op = BR_ECALL;
        endcase
    end

    // CSR ops live on the SYSTEM opcode, warp control on EXT1
    always_comb begin
        sfu_op = SFU_TMC;
        if (instr.opcode == OP_SYSTEM) begin
            case (instr.funct3[1:0])
                2'd2:    sfu_op = SFU_CSRRS;
                2'd3:    sfu_op = SFU_CSRRC;
                default: sfu_op = SFU_CSRRW;
            endcase
        end else begin
            case (instr.funct3)
                F3_WSPAWN: sfu_op = SFU_WSPAWN;
                F3_SPLIT:  sfu_op = SFU_SPLIT;
                F3_JOIN:   sfu_op = SFU_JOIN;
                F3_BAR:    sfu_op = SFU_BAR;
                F3_PRED:   sfu_op = SFU_PRED;
                default:   sfu_op = SFU_TMC;
            endcase
        end
    end

endmodule

//--- verilog/instr_decoder.sv
// Instruction decoder
// Main opcode decode of one fetched instruction into the decoded record,
// with the warp stall flag for the scheduler

`timescale 1ns/10ps

module instr_decoder (
    input  gpu_decode_pkg::fetch_t  fetch,
    output gpu_decode_pkg::decode_t dec,
    output logic                    wstall
);
    import rv_isa_pkg::*;
    import gpu_decode_pkg::*;

    rv_instr_t        instr;
    logic [31:0]      imm_i;
    logic [31:0]      imm_s;
    logic [31:0]      imm_b;
    logic [31:0]      imm_u;
    logic [31:0]      imm_j;
    logic [31:0]      imm_csr;
    alu_op_e          alu_op;
    br_op_e           br_op;
    br_op_e           sys_op;
    mul_op_e          mul_op;
    sfu_op_e          sfu_op;
    ex_type_e         ex_type;
    logic [OP_W-1:0]  op_type;
    logic [MOD_W-1:0] op_mod;
    logic [XLEN-1:0]  imm;
    logic             use_pc;
    logic             use_imm;
    logic             use_rd;
    logic             use_rs1;
    logic             use_rs2;

    assign instr = fetch.instr;

    imm_gen i_imm_gen (
        .instr   (instr),
        .imm_i   (imm_i),
        .imm_s   (imm_s),
        .imm_b   (imm_b),
        .imm_u   (imm_u),
        .imm_j   (imm_j),
        .imm_csr (imm_csr)
    );

    op_func_map i_op_map (
        .instr  (instr),
        .alu_op (alu_op),
        .br_op  (br_op),
        .sys_op (sys_op),
        .mul_op (mul_op),
        .sfu_op (sfu_op)
    );

    always_comb begin
        ex_type = EX_ALU;
        op_type = '0;
        op_mod  = '0;
        imm     = '0;
        use_pc  = 1'b0;
        use_imm = 1'b0;
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        wstall  = 1'b0;

        case (instr.opcode)
            OP_IMM: begin
                op_type = alu_op;
                {use_imm, imm} = {1'b1, imm_i};
                {use_rd, use_rs1} = 2'b11;
            end
            OP_REG: begin
                if (instr.funct7[0]) begin
                    op_type = mul_op;
                    op_mod[MOD_MULDIV] = 1'b1;
                end else begin
                    op_type = alu_op;
                end
                {use_rd, use_rs1, use_rs2} = 3'b111;
            end
            OP_LUI, OP_AUIPC: begin
                op_type = (instr.opcode == OP_LUI) ? ALU_LUI : ALU_AUIPC;
                use_pc  = (instr.opcode == OP_AUIPC);
                {use_imm, imm} = {1'b1, imm_u};
                use_rd  = 1'b1;
            end
            OP_JAL, OP_JALR, OP_BRANCH: begin
                op_mod[MOD_BRANCH] = 1'b1;
                wstall  = 1'b1;
                use_imm = 1'b1;
                if (instr.opcode == OP_JAL) begin
                    {op_type, imm, use_pc, use_rd} = {BR_JAL, imm_j, 2'b11};
                end else if (instr.opcode == OP_JALR) begin
                    {op_type, imm, use_rd, use_rs1} = {BR_JALR, imm_i, 2'b11};
                end else begin
                    {op_type, imm, use_pc} = {br_op, imm_b, 1'b1};
                    {use_rs1, use_rs2} = 2'b11;
                end
            end
            OP_LOAD, OP_STORE: begin
                ex_type = EX_LSU;
                op_type = {(instr.opcode == OP_STORE), instr.funct3};
                use_imm = 1'b1;
                imm     = (instr.opcode == OP_STORE) ? imm_s : imm_i;
                use_rs1 = 1'b1;
                use_rd  = (instr.opcode == OP_LOAD);
                use_rs2 = (instr.opcode == OP_STORE);
            end
            OP_FENCE: begin
                ex_type = EX_LSU;
                op_type = LSU_FENCE;
            end
            OP_SYSTEM: begin
                use_rd = 1'b1;
                wstall = 1'b1;
                if (instr.funct3[1:0] != 2'b00) begin  // CSR access
                    ex_type = EX_SFU;
                    op_type = sfu_op;
                    imm     = imm_csr;
                    use_imm = instr.funct3[2];
                    use_rs1 = !instr.funct3[2];
                end else begin  // Trap or return, link is pc + 4
                    op_type = sys_op;
                    op_mod[MOD_BRANCH] = 1'b1;
                    {use_pc, use_imm, imm} = {2'b11, 32'd4};
                end
            end
            OP_EXT1: begin
                if (instr.funct7 == F7_WCTL) begin
                    ex_type = EX_SFU;
                    op_type = sfu_op;
                    wstall  = 1'b1;
                    case (instr.funct3)
                        F3_TMC, F3_JOIN:         use_rs1 = 1'b1;
                        F3_SPLIT:                {use_rd, use_rs1} = 2'b11;
                        F3_WSPAWN, F3_BAR, F3_PRED: {use_rs1, use_rs2} = 2'b11;
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        dec.uuid    = fetch.uuid;
        dec.wid     = fetch.wid;
        dec.tmask   = fetch.tmask;
        dec.pc      = fetch.pc;
        dec.ex_type = ex_type;
        dec.op_type = op_type;
        dec.op_mod  = op_mod;
        dec.use_pc  = use_pc;
        dec.imm     = imm;
        dec.use_imm = use_imm;
        dec.wb      = use_rd && (instr.rd != '0);  // x0 is never written
        dec.rd      = use_rd ? instr.rd : '0;
        dec.rs1     = use_rs1 ? instr.rs1 : '0;
        dec.rs2     = use_rs2 ? instr.rs2 : '0;
    end

endmodule

//--- verilog/decode_buffer.sv
// Decode output register
// One-entry pipe stage with valid/ready, full throughput and flush

`timescale 1ns/10ps

module decode_buffer (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    valid_in,
    output logic                    ready_in,
    input  gpu_decode_pkg::decode_t data_in,
    output logic                    valid_out,
    input  logic                    ready_out,
    output gpu_decode_pkg::decode_t data_out
);
    import gpu_decode_pkg::*;

    logic    full;
    decode_t data_q;

    // Take a new item when empty or when the held one leaves this cycle
    assign ready_in = !full || ready_out;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (flush) begin
            full <= 1'b0;  // Drops held and incoming item
        end else if (ready_in) begin
            full <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (valid_in && ready_in) begin
            data_q <= data_in;
        end
    end

    assign valid_out = full;
    assign data_out  = data_q;

endmodule

//--- verilog/gpu_decode.sv
// SIMT GPU decode stage
// Decodes fetched RV32IM and warp-control instructions, registers the
// result behind a valid/ready handshake and notifies the warp scheduler

`timescale 1ns/10ps

module gpu_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    flush,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    input  gpu_decode_pkg::fetch_t  fetch,
    output logic                    decode_valid,
    input  logic                    decode_ready,
    output gpu_decode_pkg::decode_t decode,
    output gpu_decode_pkg::sched_t  sched
);
    import gpu_decode_pkg::*;

    decode_t dec;
    logic    wstall;
    logic    fetch_fire;

    instr_decoder i_decoder (
        .fetch  (fetch),
        .dec    (dec),
        .wstall (wstall)
    );

    decode_buffer i_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (flush),
        .valid_in  (fetch_valid),
        .ready_in  (fetch_ready),
        .data_in   (dec),
        .valid_out (decode_valid),
        .ready_out (decode_ready),
        .data_out  (decode)
    );

    assign fetch_fire = fetch_valid && fetch_ready;

    // Scheduler sees the stall in the accept cycle
    assign sched = '{valid: fetch_fire, wid: fetch.wid, wstall: wstall};

endmodule

//--- tests/tb_clock_gen.sv
// Testbench clock and reset
// Free-running clock, active-low reset held for a few cycles

`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst_n = 1'b1;
    end
endmodule

//--- tests/decode_ref.svh
// Decode reference model
// Instruction encoders and the expected decode of one fetch record

`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
        input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
        input logic [6:0] opc);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
endfunction

// Sign-extend from bit w-1
function automatic logic [31:0] sext(input logic [31:0] v, input int w);
    logic [31:0] m;
    m = 32'hFFFF_FFFF << w;
    return v[w-1] ? (v | m) : (v & ~m);
endfunction

function automatic logic [3:0] alu_code(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? ALU_SUB : ALU_ADD;
        3'd1:    return ALU_SLL;
        3'd2:    return ALU_SLT;
        3'd3:    return ALU_SLTU;
        3'd4:    return ALU_XOR;
        3'd5:    return alt ? ALU_SRA : ALU_SRL;
        3'd6:    return ALU_OR;
        default: return ALU_AND;
    endcase
endfunction

function automatic decode_t expected_decode(input fetch_t f, output logic stall);
    decode_t     d;
    logic [31:0] ir;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic        rd_u;
    logic        rs1_u;
    logic        rs2_u;
    ir    = f.instr;
    f3    = ir[14:12];
    f7    = ir[31:25];
    d     = '0;
    stall = 1'b0;
    rd_u  = 1'b0;
    rs1_u = 1'b0;
    rs2_u = 1'b0;
    case (ir[6:0])
        7'h13: begin  // OP-IMM
            d.op_type = alu_code(f3, (f3 == 3'd5) && f7[5]);
            d.use_imm = 1'b1;
            d.imm     = (f3 == 3'd1 || f3 == 3'd5) ? {27'b0, ir[24:20]} : sext(ir[31:20], 12);
            rd_u      = 1'b1;
            rs1_u     = 1'b1;
        end
        7'h33: begin  // OP-REG
            if (f7[0]) begin
                d.op_type = {1'b0, f3};
                d.op_mod  = 3'b010;
            end else begin
                d.op_type = alu_code(f3, f7[5]);
            end
            rd_u  = 1'b1;
            rs1_u = 1'b1;
            rs2_u = 1'b1;
        end
        7'h37, 7'h17: begin  // LUI has bit 5 set, AUIPC not
            d.op_type = ir[5] ? ALU_LUI : ALU_AUIPC;
            d.use_pc  = !ir[5];
            d.use_imm = 1'b1;
            d.imm     = {ir[31:12], 12'h000};
            rd_u      = 1'b1;
        end
        7'h6F, 7'h67, 7'h63: begin
            d.op_mod  = 3'b001;
            d.use_imm = 1'b1;
            stall     = 1'b1;
            if (ir[6:0] == 7'h6F) begin
                d.op_type = BR_JAL;
                d.use_pc  = 1'b1;
                d.imm     = sext({ir[31], ir[19:12], ir[20], ir[30:21], 1'b0}, 21);
                rd_u      = 1'b1;
            end else if (ir[6:0] == 7'h67) begin
                d.op_type = BR_JALR;
                d.imm     = sext(ir[31:20], 12);
                rd_u      = 1'b1;
                rs1_u     = 1'b1;
            end else begin
                case (f3)
                    3'd1:    d.op_type = BR_NE;
                    3'd4:    d.op_type = BR_LT;
                    3'd5:    d.op_type = BR_GE;
                    3'd6:    d.op_type = BR_LTU;
                    3'd7:    d.op_type = BR_GEU;
                    default: d.op_type = BR_EQ;
                endcase
                d.use_pc = 1'b1;
                d.imm    = sext({ir[31], ir[7], ir[30:25], ir[11:8], 1'b0}, 13);
                rs1_u    = 1'b1;
                rs2_u    = 1'b1;
            end
        end
        7'h03, 7'h23: begin  // Stores have bit 5 set
            d.ex_type = EX_LSU;
            d.op_type = {ir[5], f3};
            d.use_imm = 1'b1;
            d.imm     = ir[5] ? sext({f7, ir[11:7]}, 12) : sext(ir[31:20], 12);
            rs1_u     = 1'b1;
            rd_u      = !ir[5];
            rs2_u     = ir[5];
        end
        7'h0F: begin
            d.ex_type = EX_LSU;
            d.op_type = 4'd15;
        end
        7'h73: begin
            stall = 1'b1;
            rd_u  = 1'b1;
            if (f3[1:0] != 2'd0) begin
                d.ex_type    = EX_SFU;
                d.op_type    = 4'd5 + {2'b00, f3[1:0]};  // CSRRW is 6
                d.imm[11:0]  = ir[31:20];
                if (f3[2]) begin
                    d.imm[16:12] = ir[19:15];
                    d.use_imm    = 1'b1;
                end else begin
                    rs1_u = 1'b1;
                end
            end else begin
                case (ir[31:20])
                    12'h001: d.op_type = BR_EBREAK;
                    12'h002: d.op_type = BR_URET;
                    12'h102: d.op_type = BR_SRET;
                    12'h302: d.op_type = BR_MRET;
                    default: d.op_type = BR_ECALL;
                endcase
                d.op_mod  = 3'b001;
                d.use_pc  = 1'b1;
                d.use_imm = 1'b1;
                d.imm     = 32'd4;
            end
        end
        7'h0B: begin
            if (f7 == 7'h00) begin
                d.ex_type = EX_SFU;
                d.op_type = (f3 <= 3'd5) ? {1'b0, f3} : 4'd0;
                stall     = 1'b1;
                rs1_u     = (f3 <= 3'd5);
                rs2_u     = (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd5);
                rd_u      = (f3 == 3'd2);
            end
        end
        default: ;
    endcase
    d.uuid  = f.uuid;
    d.wid   = f.wid;
    d.tmask = f.tmask;
    d.pc    = f.pc;
    d.rd    = rd_u ? ir[11:7] : 5'd0;
    d.rs1   = rs1_u ? ir[19:15] : 5'd0;
    d.rs2   = rs2_u ? ir[24:20] : 5'd0;
    d.wb    = rd_u && (ir[11:7] != 5'd0);
    return d;
endfunction

`endif

//--- tests/decode_tb.sv
// Decode stage testbench
// Random instruction streams with a reference model, back-pressure and flush

`timescale 1ns/10ps

module decode_tb;
    import rv_isa_pkg::*;
    import gpu_decode_pkg::*;

    `include "decode_ref.svh"

    localparam int          CLK_PERIOD = 8;
    localparam int unsigned SEED       = 32'h2ece3ae0;
    localparam int          N_ALU      = 60;
    localparam int          N_CTRL     = 40;
    localparam int          N_MEM      = 60;
    localparam int          N_BP       = 80;
    localparam int          N_TAIL     = 8;
    localparam int          NUM_ITEMS  = N_ALU + N_CTRL + N_MEM + N_BP + 2 + N_TAIL;
    localparam int          MAX_CYCLES = NUM_ITEMS * 20 + 200;

    logic      clk;
    logic      rst_n;
    logic      flush;
    logic      fetch_valid;
    logic      fetch_ready;
    fetch_t    fetch;
    logic      decode_valid;
    logic      decode_ready;
    decode_t   decode;
    sched_t    sched;

    decode_t    exp_q[$];
    int         n_checks = 0;
    int         n_errors = 0;
    logic [1:0] ready_mode;  // 0 always ready, 1 random, 2 stalled
    logic [7:0] uuid_cnt;
    logic       hold_valid = 1'b0;
    decode_t    held;
    logic       check_idle = 1'b0;
    logic       exp_full   = 1'b0;  // Modelled buffer occupancy

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(2)) i_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    gpu_decode i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .fetch_valid  (fetch_valid),
        .fetch_ready  (fetch_ready),
        .fetch        (fetch),
        .decode_valid (decode_valid),
        .decode_ready (decode_ready),
        .decode       (decode),
        .sched        (sched)
    );

    task automatic check_val(input logic [127:0] got, input logic [127:0] exp,
            input string what);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, what, got, exp);
        end
    endtask

    // Legal encodings of class 0 (ALU, M), 1 (control flow) or 2 (memory, CSR, warp)
    function automatic logic [31:0] rand_instr(input int unsigned cls);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [31:0] r;
        logic [6:0]  f7;
        logic [11:0] f12;
        logic [11:0] sh_imm;
        int unsigned pick;
        rd   = (($urandom % 4) == 0) ? 5'd0 : 5'($urandom);
        rs1  = 5'($urandom);
        rs2  = 5'($urandom);
        f3   = 3'($urandom);
        r    = $urandom;
        pick = $urandom % 6;
        f7   = r[0] ? 7'h01 : (r[1] ? 7'h20 : 7'h00);
        case (r[4:2] % 3'd5)
            3'd1:    f12 = 12'h001;
            3'd2:    f12 = 12'h002;
            3'd3:    f12 = 12'h102;
            3'd4:    f12 = 12'h302;
            default: f12 = 12'h000;
        endcase
        if (f3 == 3'd1)
            sh_imm = {7'h00, r[24:20]};
        else if (f3 == 3'd5)
            sh_imm = {r[5] ? 7'h20 : 7'h00, r[24:20]};
        else
            sh_imm = r[31:20];
        if (cls == 0) begin
            case (pick % 4)
                0:       return r_type(f7, rs2, rs1, f3, rd, 7'h33);
                1:       return i_type(sh_imm, rs1, f3, rd, 7'h13);
                2:       return u_type(r[31:12], rd, 7'h37);
                default: return u_type(r[31:12], rd, 7'h17);
            endcase
        end else if (cls == 1) begin
            case (pick % 4)
                0:       return b_type({r[12:1], 1'b0}, rs2, rs1,
                                       (f3 == 3'd2 || f3 == 3'd3) ? f3 + 3'd2 : f3);
                1:       return j_type({r[20:1], 1'b0}, rd);
                2:       return i_type(r[11:0], rs1, 3'd0, rd, 7'h67);
                default: return i_type(f12, 5'd0, 3'd0, rd, 7'h73);
            endcase
        end else begin
            case (pick)
                0:       return i_type(r[11:0], rs1, (f3 == 3'd3 || f3 >= 3'd6) ? 3'd2 : f3,
                                       rd, 7'h03);
                1:       return s_type(r[11:0], rs2, rs1, f3 % 3'd3);
                2:       return {r[31:7], 7'h0F};
                3:       return i_type(r[11:0], rs1, (f3[1:0] == 2'd0) ? (f3 | 3'd1) : f3,
                                       rd, 7'h73);
                4:       return r_type(7'h00, rs2, rs1, f3 % 3'd6, rd, 7'h0B);
                default: return r[0] ? r_type({1'b1, r[6:1]}, rs2, rs1, f3, rd, 7'h0B)
                                     : {r[31:7], 7'h5B};  // Unknown opcodes
            endcase
        end
    endfunction

    task automatic send_fetch(input logic [31:0] instr);
        logic acc;
        fetch.uuid  = uuid_cnt;
        fetch.wid   = 2'($urandom);
        fetch.tmask = 4'($urandom);
        fetch.pc    = $urandom & 32'hFFFF_FFFC;
        fetch.instr = instr;
        fetch_valid = 1'b1;
        acc = 1'b0;
        while (!acc) begin
            @(negedge clk);
            acc = fetch_ready;
            @(posedge clk);
            #1;
        end
        fetch_valid = 1'b0;
        uuid_cnt++;
    endtask

    task automatic wait_drain();
        @(posedge clk);
        #1;
        while (exp_q.size() != 0 || decode_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    always @(posedge clk) begin
        #1;
        case (ready_mode)
            2'd1:    decode_ready = ($urandom % 3) != 0;
            2'd2:    decode_ready = 1'b0;
            default: decode_ready = 1'b1;
        endcase
    end

    // Scoreboard samples at the falling edge once handshakes have settled
    always @(negedge clk) begin : monitor
        decode_t exp_d;
        logic    stall;
        if (rst_n) begin
            if (check_idle) begin
                check_val(128'(decode_valid), 128'(0), "decode_valid after flush");
                check_idle = 1'b0;
            end
            if (hold_valid && decode_valid)
                check_val(128'(decode), 128'(held), "decode stable while stalled");
            if (flush) begin
                if (decode_valid && exp_q.size() > 0)
                    void'(exp_q.pop_front());  // Flushed item never leaves
                check_idle = 1'b1;
            end else if (decode_valid && decode_ready) begin
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("Error at %0t: decode transfer with no item expected", $time);
                end else begin
                    check_val(128'(decode), 128'(exp_q.pop_front()), "decoded record");
                end
            end
            hold_valid = decode_valid && !decode_ready && !flush;
            held       = decode;
            if (fetch_valid && fetch_ready) begin
                exp_d = expected_decode(fetch, stall);
                check_val(128'(sched), 128'({1'b1, fetch.wid, stall}), "scheduler notify");
                if (!flush)
                    exp_q.push_back(exp_d);
            end else begin
                check_val(128'(sched.valid), 128'(0), "sched.valid without accept");
            end
            check_val(128'(fetch_ready), 128'(!exp_full || decode_ready), "fetch_ready");
            if (flush)
                exp_full = 1'b0;
            else if (!exp_full || decode_ready)
                exp_full = fetch_valid;
        end
    end

    initial begin : stimulus
        void'($urandom(SEED));
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch        = '0;
        decode_ready = 1'b0;
        ready_mode   = 2'd0;
        uuid_cnt     = 8'd0;
        wait (rst_n === 1'b1);
        @(negedge clk);
        check_val(128'(decode_valid), 128'(0), "decode_valid after reset");
        check_val(128'(sched.valid), 128'(0), "sched.valid after reset");
        @(posedge clk);
        #1;
        for (int i = 0; i < N_ALU; i++)
            send_fetch(rand_instr(0));
        for (int i = 0; i < N_CTRL; i++)
            send_fetch(rand_instr(1));
        for (int i = 0; i < N_MEM; i++)
            send_fetch(rand_instr(2));
        ready_mode = 2'd1;
        for (int i = 0; i < N_BP; i++)
            send_fetch(rand_instr($urandom % 3));
        ready_mode = 2'd0;
        wait_drain();

        // Flush a held item, then flush with a fetch in the same cycle
        ready_mode = 2'd2;
        @(posedge clk);
        #1;
        send_fetch(rand_instr(0));
        flush = 1'b1;
        @(posedge clk);
        #1;
        send_fetch(rand_instr(2));
        flush = 1'b0;

        ready_mode = 2'd0;
        for (int i = 0; i < N_TAIL; i++)
            send_fetch(rand_instr($urandom % 3));
        wait_drain();
        repeat (2) @(posedge clk);

        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin : watchdog
        #(CLK_PERIOD * MAX_CYCLES);
        $display("Timeout: run did not finish within %0d cycles, errors so far %0d",
                 MAX_CYCLES, n_errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+tests
verilog/rv_isa_pkg.sv
verilog/gpu_decode_pkg.sv
verilog/imm_gen.sv
verilog/op_func_map.sv
verilog/instr_decoder.sv
verilog/decode_buffer.sv
verilog/gpu_decode.sv
tests/tb_clock_gen.sv
tests/decode_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only -Wall --timing
TOP        = decode_tb
FILELIST   = build.f
OBJ_DIR    = obj_dir
PASS_TEXT  = *** PASSED ***

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
